// ==== rs_params.svh ====
// Compile-time sizes only; RS_ENTRIES must be at least 2 and RS_IDX_W follows from it
`ifndef RS_PARAMS_SVH
`define RS_PARAMS_SVH

// --------------------------------------------------
// Station geometry
// --------------------------------------------------

// Entry count
`define RS_ENTRIES 8

// Entry index width
`define RS_IDX_W $clog2(`RS_ENTRIES)

// --------------------------------------------------
// Operand and payload widths
// --------------------------------------------------

// Physical tag
`define RS_TAG_W 6

// Opaque payload
`define RS_OP_W 16

`endif

// ==== rs_pkg.sv ====
// Types only; only ALU and MEM classes exist and operand values are never carried
`include "rs_params.svh"

package rs_pkg;

    // --------------------------------------------------
    // Width types
    // --------------------------------------------------
    typedef logic [`RS_TAG_W-1:0] tag_t;
    typedef logic [`RS_IDX_W-1:0] rs_idx_t;
    typedef logic [`RS_OP_W-1:0]  op_t;

    // Functional unit class of an instruction
    typedef enum logic [0:0] {
        FU_ALU,
        FU_MEM
    } fu_class_t;

    // Per-entry lifecycle
    typedef enum logic [1:0] {
        ENT_FREE,
        ENT_WAIT,
        ENT_READY
    } entry_state_t;

    // --------------------------------------------------
    // Bus structs
    // --------------------------------------------------

    // Decoded instruction from dispatch
    typedef struct packed {
        op_t       op;
        fu_class_t fu;
        tag_t      dest;
        tag_t      src1;
        logic      src1_rdy;
        tag_t      src2;
        logic      src2_rdy;
    } rs_inst_t;

    // One completion broadcast
    typedef struct packed {
        logic valid;
        tag_t tag;
    } cdb_t;

    // Fields handed to a functional unit
    typedef struct packed {
        op_t       op;
        fu_class_t fu;
        tag_t      dest;
    } issue_t;

endpackage

// ==== rs_entry.sv ====
// Single slot; alloc_i must only hit a free slot and grant_i only a requesting one
`timescale 1ns/1ns
`include "rs_params.svh"

module rs_entry
    import rs_pkg::*;
(
    input  logic     clk_i,
    input  logic     rst_i,
    input  logic     flush_i,
    input  logic     alloc_i,
    input  rs_inst_t inst_i,
    input  cdb_t     cdb_i,
    input  logic     alu_ready_i,
    input  logic     mem_ready_i,
    input  logic     grant_i,
    output logic     free_o,
    output logic     req_o,
    output issue_t   issue_o
);

    entry_state_t state_q;
    rs_inst_t     inst_q;
    // Instruction seen by the wakeup compare this cycle
    rs_inst_t     inst_cur;
    logic         hit1;
    logic         hit2;
    logic         rdy1_nxt;
    logic         rdy2_nxt;
    logic         class_ready;

    // --------------------------------------------------
    // Wakeup
    // --------------------------------------------------
    // Incoming instruction while being written and the stored one otherwise
    assign inst_cur = alloc_i ? inst_i : inst_q;

    assign hit1     = cdb_i.valid && (cdb_i.tag == inst_cur.src1);
    assign hit2     = cdb_i.valid && (cdb_i.tag == inst_cur.src2);
    assign rdy1_nxt = inst_cur.src1_rdy || hit1;
    assign rdy2_nxt = inst_cur.src2_rdy || hit2;

    // Lifecycle FSM with flush winning over everything
    always_ff @(posedge clk_i) begin
        if (rst_i || flush_i) begin
            state_q <= ENT_FREE;
        end else begin
            case (state_q)
                ENT_FREE: begin
                    if (alloc_i) begin
                        state_q <= (rdy1_nxt && rdy2_nxt) ? ENT_READY : ENT_WAIT;
                    end
                end
                ENT_WAIT: begin
                    if (rdy1_nxt && rdy2_nxt) begin
                        state_q <= ENT_READY;
                    end
                end
                ENT_READY: begin
                    if (grant_i) begin
                        state_q <= ENT_FREE;
                    end
                end
                default: state_q <= ENT_FREE;
            endcase
        end
    end

    // Payload plus sticky ready bits
    always_ff @(posedge clk_i) begin
        if (alloc_i || (state_q == ENT_WAIT)) begin
            inst_q          <= inst_cur;
            inst_q.src1_rdy <= rdy1_nxt;
            inst_q.src2_rdy <= rdy2_nxt;
        end
    end

    // --------------------------------------------------
    // Issue request
    // --------------------------------------------------
    assign class_ready = (inst_q.fu == FU_MEM) ? mem_ready_i : alu_ready_i;
    // No request in a flush cycle
    assign req_o       = (state_q == ENT_READY) && class_ready && !flush_i;
    assign free_o      = (state_q == ENT_FREE);

    assign issue_o.op   = inst_q.op;
    assign issue_o.fu   = inst_q.fu;
    assign issue_o.dest = inst_q.dest;

    // Allocator never overwrites a live slot
    a_alloc_free: assert property (@(posedge clk_i) disable iff (rst_i)
        alloc_i |-> (state_q == ENT_FREE));

    // Arbiter grants only requesters
    a_grant_req: assert property (@(posedge clk_i) disable iff (rst_i)
        grant_i |-> req_o);

endmodule

// ==== rs_alloc.sv ====
// Purely combinational; one instruction per cycle, lowest free index wins
`timescale 1ns/1ns
`include "rs_params.svh"

module rs_alloc
    import rs_pkg::*;
(
    input  logic                   dp_valid_i,
    input  logic [`RS_ENTRIES-1:0] free_i,
    output logic                   dp_ready_o,
    output logic [`RS_ENTRIES-1:0] alloc_o
);

    // Lowest free slot
    rs_idx_t pick_idx;

    // --------------------------------------------------
    // Priority select and write decode
    // --------------------------------------------------
    always_comb begin
        pick_idx   = '0;
        dp_ready_o = 1'b0;
        alloc_o    = '0;

        // Scan top down so the lowest free slot is written last
        for (int i = `RS_ENTRIES - 1; i >= 0; i--) begin
            if (free_i[i]) begin
                pick_idx   = rs_idx_t'(i);
                dp_ready_o = 1'b1;
            end
        end

        // Write strobe only on an actual transfer
        if (dp_valid_i && dp_ready_o) begin
            alloc_o[pick_idx] = 1'b1;
        end

        // At most one slot written
        a_alloc_onehot: assert ($onehot0(alloc_o))
            else $error("alloc_o %b has more than one slot set", alloc_o);
    end

endmodule

// ==== rs_issue_arbiter.sv ====
// Round-robin over all slots; grant and issue bus are combinational from req_i
`timescale 1ns/1ns
`include "rs_params.svh"

module rs_issue_arbiter
    import rs_pkg::*;
(
    input  logic                     clk_i,
    input  logic                     rst_i,
    input  logic   [`RS_ENTRIES-1:0] req_i,
    input  issue_t [`RS_ENTRIES-1:0] entry_issue_i,
    output logic   [`RS_ENTRIES-1:0] grant_o,
    output logic                     issue_valid_o,
    output issue_t                   issue_o
);

    // Highest-priority slot this cycle
    rs_idx_t ptr_q;
    rs_idx_t win_idx;

    // --------------------------------------------------
    // Grant search starting at the pointer
    // --------------------------------------------------
    always_comb begin
        int cand;

        cand          = 0;
        win_idx       = ptr_q;
        issue_valid_o = 1'b0;
        grant_o       = '0;

        for (int k = 0; k < `RS_ENTRIES; k++) begin
            cand = (int'(ptr_q) + k) % `RS_ENTRIES;
            // First hit after the pointer wins
            if (!issue_valid_o && req_i[cand]) begin
                issue_valid_o = 1'b1;
                win_idx       = rs_idx_t'(cand);
            end
        end

        if (issue_valid_o) begin
            grant_o[win_idx] = 1'b1;
        end
    end

    // Winner's fields onto the bus
    assign issue_o = entry_issue_i[win_idx];

    // Pointer moves past the winner and wraps at the last slot
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            ptr_q <= '0;
        end else if (issue_valid_o) begin
            if (win_idx == rs_idx_t'(`RS_ENTRIES - 1)) begin
                ptr_q <= '0;
            end else begin
                ptr_q <= win_idx + 1'b1;
            end
        end
    end

    a_grant_onehot: assert property (@(posedge clk_i) disable iff (rst_i)
        issue_valid_o |-> $onehot(grant_o));

endmodule

// ==== reservation_station.sv ====
// Single dispatch, single CDB, single issue; flush_i beats dispatch, wakeup and issue
`timescale 1ns/1ns
`include "rs_params.svh"

module reservation_station
    import rs_pkg::*;
(
    input  logic     clk_i,
    input  logic     rst_i,
    input  logic     flush_i,
    // Dispatch handshake
    input  logic     dp_valid_i,
    input  rs_inst_t dp_inst_i,
    output logic     dp_ready_o,
    // Completion broadcast
    input  cdb_t     cdb_i,
    // Functional unit availability
    input  logic     alu_ready_i,
    input  logic     mem_ready_i,
    // Issue bus
    output logic     issue_valid_o,
    output issue_t   issue_o
);

    logic   [`RS_ENTRIES-1:0] entry_free;
    logic   [`RS_ENTRIES-1:0] entry_alloc;
    logic   [`RS_ENTRIES-1:0] entry_req;
    logic   [`RS_ENTRIES-1:0] entry_grant;
    issue_t [`RS_ENTRIES-1:0] entry_issue;

    // --------------------------------------------------
    // Slot allocation
    // --------------------------------------------------
    rs_alloc i_rs_alloc (
        .dp_valid_i (dp_valid_i),
        .free_i     (entry_free),
        .dp_ready_o (dp_ready_o),
        .alloc_o    (entry_alloc)
    );

    // --------------------------------------------------
    // Entry array
    // --------------------------------------------------
    for (genvar e = 0; e < `RS_ENTRIES; e++) begin : g_entry
        rs_entry i_rs_entry (
            .clk_i       (clk_i),
            .rst_i       (rst_i),
            .flush_i     (flush_i),
            .alloc_i     (entry_alloc[e]),
            .inst_i      (dp_inst_i),
            .cdb_i       (cdb_i),
            .alu_ready_i (alu_ready_i),
            .mem_ready_i (mem_ready_i),
            .grant_i     (entry_grant[e]),
            .free_o      (entry_free[e]),
            .req_o       (entry_req[e]),
            .issue_o     (entry_issue[e])
        );
    end

    // --------------------------------------------------
    // Issue selection
    // --------------------------------------------------
    rs_issue_arbiter i_rs_issue_arbiter (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .req_i         (entry_req),
        .entry_issue_i (entry_issue),
        .grant_o       (entry_grant),
        .issue_valid_o (issue_valid_o),
        .issue_o       (issue_o)
    );

endmodule

// ==== tb_reservation_station.sv ====
// Self-checking run; op payloads count from 1 and must stay below MAX_OPS, first mismatch ends it
`timescale 1ns/1ns
`include "rs_params.svh"

module tb_reservation_station
    import rs_pkg::*;
();

    localparam int CLK_HALF    = 20;
    localparam int DRIVE_DLY   = 5;
    localparam int RST_CYCLES  = 2;
    localparam int FILL_CYCLES = 12;
    localparam int MIX_CYCLES  = 300;
    localparam int DRAIN_OPS   = 12;
    // About 350 cycles of stimulus plus slack for the drain
    localparam int CYCLE_LIMIT = 600;
    localparam int MAX_OPS     = 1024;
    // Stimulus modes
    localparam int FILL  = 0;
    localparam int MIX   = 1;
    localparam int DRAIN = 2;

    logic     clk_i;
    logic     rst_i;
    logic     flush_i;
    logic     dp_valid_i;
    rs_inst_t dp_inst_i;
    logic     dp_ready_o;
    cdb_t     cdb_i;
    logic     alu_ready_i;
    logic     mem_ready_i;
    logic     issue_valid_o;
    issue_t   issue_o;

    // Scoreboard indexed by op payload
    rs_inst_t    op_inst [MAX_OPS];
    logic        op_ok1 [MAX_OPS];
    logic        op_ok2 [MAX_OPS];
    // Ops currently held by the station
    int          live_q[$];
    logic [15:0] lfsr;
    int          cycle_cnt = 0;
    int          next_op;
    int          drain_first;
    logic        last_xfer;

    // Check terms built mid-cycle and sampled at the closing edge
    logic   exp_ready;
    logic   got_ready;
    logic   exp_valid;
    logic   got_valid;
    logic   issue_ok;
    issue_t exp_issue;
    issue_t got_issue;

    reservation_station i_reservation_station (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .flush_i       (flush_i),
        .dp_valid_i    (dp_valid_i),
        .dp_inst_i     (dp_inst_i),
        .dp_ready_o    (dp_ready_o),
        .cdb_i         (cdb_i),
        .alu_ready_i   (alu_ready_i),
        .mem_ready_i   (mem_ready_i),
        .issue_valid_o (issue_valid_o),
        .issue_o       (issue_o)
    );

    always #CLK_HALF clk_i = ~clk_i;

    // --------------------------------------------------
    // Helpers
    // --------------------------------------------------
    // Fibonacci taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // One LFSR step per bit
    task automatic draw_bits(input int n, output int val);
        val = 0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsr_step(lfsr);
            val  = (val << 1) | int'(lfsr[0]);
        end
    endtask

    function automatic logic class_ready_for(input fu_class_t fu, input logic alu, input logic mem);
        return (fu == FU_MEM) ? mem : alu;
    endfunction

    task automatic report_mismatch(input string name, input int exp_val, input int got_val);
        $display("[FAIL] t=%0t %s expected %0h actual %0h", $time, name, exp_val, got_val);
        $display("TEST FAIL");
        $fatal(1, "stopped at the first mismatch");
    endtask

    task automatic abort_run(input string msg);
        $display("Error at t=%0t: %s", $time, msg);
        $display("TEST FAIL");
        $fatal(1, "stopped on error");
    endtask

    // Inputs for one cycle, applied just after the rising edge
    task automatic drive_cycle(input int mode, input logic allow_new);
        tag_t     pend[$];
        int       b;
        int       idx;
        rs_inst_t ins;

        @(posedge clk_i);
        #DRIVE_DLY;
        flush_i = 1'b0;
        // Refused instruction stays on the bus unchanged
        if (!(dp_valid_i && !last_xfer)) begin
            b = 1;
            if (mode == MIX) draw_bits(1, b);
            dp_valid_i = allow_new && b[0];
            if (dp_valid_i) begin
                draw_bits(21, b);
                ins.op       = op_t'(next_op);
                ins.fu       = fu_class_t'(b[20]);
                ins.dest     = tag_t'(b[19:14]);
                ins.src1     = tag_t'(b[13:8]);
                ins.src2     = tag_t'(b[7:2]);
                // Fill keeps every source waiting
                ins.src1_rdy = (mode != FILL) && b[1];
                ins.src2_rdy = (mode != FILL) && b[0];
                dp_inst_i    = ins;
                next_op++;
            end
        end
        // CDB carries one still-outstanding source tag or nothing
        cdb_i = '0;
        foreach (live_q[i]) begin
            if (!op_ok1[live_q[i]]) pend.push_back(op_inst[live_q[i]].src1);
            if (!op_ok2[live_q[i]]) pend.push_back(op_inst[live_q[i]].src2);
        end
        b = (mode == DRAIN) ? 1 : 0;
        if (mode == MIX) draw_bits(1, b);
        if (b[0] && pend.size() > 0) begin
            draw_bits(4, idx);
            cdb_i.valid = 1'b1;
            cdb_i.tag   = pend[idx % pend.size()];
        end
        // Both units open while draining
        draw_bits(2, b);
        alu_ready_i = (mode == DRAIN) || b[1];
        mem_ready_i = (mode == DRAIN) || b[0];
    endtask

    // --------------------------------------------------
    // Reference model evaluated at the falling edge
    // --------------------------------------------------
    always @(negedge clk_i) begin
        int       pos;
        int       id;
        rs_inst_t cur;

        pos       = -1;
        got_ready = dp_ready_o;
        got_valid = issue_valid_o;
        got_issue = issue_o;
        // Slot freed by an issue is usable one cycle later
        exp_ready = (live_q.size() < `RS_ENTRIES);
        exp_valid = 1'b0;
        foreach (live_q[i]) begin
            cur = op_inst[live_q[i]];
            if (op_ok1[live_q[i]] && op_ok2[live_q[i]]
                && class_ready_for(cur.fu, alu_ready_i, mem_ready_i)) exp_valid = 1'b1;
            if (cur.op == issue_o.op) pos = i;
        end
        // Flush cycle issues nothing
        exp_valid = exp_valid && !flush_i;
        // Unknown op expects all ones as no payload gets that value
        exp_issue = '1;
        issue_ok  = 1'b0;
        if (pos >= 0) begin
            id             = live_q[pos];
            exp_issue.op   = op_inst[id].op;
            exp_issue.fu   = op_inst[id].fu;
            exp_issue.dest = op_inst[id].dest;
            issue_ok       = op_ok1[id] && op_ok2[id]
                             && class_ready_for(op_inst[id].fu, alu_ready_i, mem_ready_i);
        end

        // Book this cycle's events
        last_xfer = dp_valid_i && dp_ready_o && !rst_i;
        if (rst_i || flush_i) begin
            live_q.delete();
        end else begin
            if (issue_valid_o && pos >= 0) live_q.delete(pos);
            if (last_xfer) begin
                id          = int'(dp_inst_i.op);
                op_inst[id] = dp_inst_i;
                op_ok1[id]  = dp_inst_i.src1_rdy;
                op_ok2[id]  = dp_inst_i.src2_rdy;
                live_q.push_back(id);
            end
            // Broadcast in the acceptance cycle counts as well
            if (cdb_i.valid) begin
                foreach (live_q[i]) begin
                    if (op_inst[live_q[i]].src1 == cdb_i.tag) op_ok1[live_q[i]] = 1'b1;
                    if (op_inst[live_q[i]].src2 == cdb_i.tag) op_ok2[live_q[i]] = 1'b1;
                end
            end
        end
    end

    a_dp_ready: assert property (@(posedge clk_i) disable iff (rst_i) got_ready == exp_ready)
        else report_mismatch("dp_ready_o", int'(exp_ready), int'(got_ready));
    a_issue_valid: assert property (@(posedge clk_i) disable iff (rst_i) got_valid == exp_valid)
        else report_mismatch("issue_valid_o", int'(exp_valid), int'(got_valid));
    a_issue_fields: assert property (@(posedge clk_i) disable iff (rst_i)
        got_valid |-> (got_issue == exp_issue))
        else report_mismatch("issue_o", int'(exp_issue), int'(got_issue));
    a_issue_allowed: assert property (@(posedge clk_i) disable iff (rst_i) got_valid |-> issue_ok)
        else abort_run($sformatf("op %0h issued before its sources or unit were ready",
                                 got_issue.op));

    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            abort_run($sformatf("run passed %0d cycles with %0d ops still in the station",
                                CYCLE_LIMIT, live_q.size()));
        end
    end

    // --------------------------------------------------
    // Test sequence
    // --------------------------------------------------
    initial begin
        clk_i       = 1'b0;
        rst_i       = 1'b1;
        flush_i     = 1'b0;
        dp_valid_i  = 1'b0;
        dp_inst_i   = '0;
        cdb_i       = '0;
        alu_ready_i = 1'b0;
        mem_ready_i = 1'b0;
        lfsr        = 16'd38;
        next_op     = 1;
        repeat (RST_CYCLES) @(posedge clk_i);
        #DRIVE_DLY;
        rst_i = 1'b0;

        // Silent CDB while the station fills and then refuses
        repeat (FILL_CYCLES) drive_cycle(FILL, 1'b1);
        repeat (MIX_CYCLES) drive_cycle(MIX, 1'b1);

        // Flush drops whatever is held and withdraws pending dispatch
        @(posedge clk_i);
        #DRIVE_DLY;
        flush_i    = 1'b1;
        dp_valid_i = 1'b0;
        cdb_i      = '0;

        // Drain until every new op has issued
        drain_first = next_op;
        do begin
            drive_cycle(DRAIN, (next_op - drain_first) < DRAIN_OPS);
        end while ((next_op - drain_first) < DRAIN_OPS || dp_valid_i || live_q.size() != 0);
        repeat (2) drive_cycle(DRAIN, 1'b0);

        $display("TEST PASS");
        $finish;
    end

endmodule

// ==== files.f ====
+incdir+.
rs_pkg.sv
rs_entry.sv
rs_alloc.sv
rs_issue_arbiter.sv
reservation_station.sv
tb_reservation_station.sv

// ==== run.sh ====
#!/bin/sh
# Compile and run the reservation station testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f files.f --top-module tb_reservation_station -o tb_sim
./obj_dir/tb_sim
